/* hdl/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode
    import rv_isa_pkg::*;
    import branch_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_req,
    output logic            issue_ack,
    input  logic [ilen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_val,
    input  logic [xlen-1:0] rs2_val,
    stage_if.src            dec_out
);

    logic [opcode_w-1:0] opcode;
    logic [reg_w-1:0]    rd;
    logic [reg_w-1:0]    rs1;
    logic [xlen-1:0]     imm_j;
    logic [xlen-1:0]     imm_i;
    logic [xlen-1:0]     imm_b;
    logic                rd_is_link;
    logic                rs1_is_link;
    logic                slot_free;
    logic                capture;
    decoded_branch_t     rec;

    ////////////////////////////////////////////////////////////
    // field extraction
    ////////////////////////////////////////////////////////////
    assign opcode = instr[opcode_lsb +: opcode_w];
    assign rd     = instr[rd_lsb +: reg_w];
    assign rs1    = instr[rs1_lsb +: reg_w];

    // J and B immediates are in halfwords
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    assign rd_is_link  = (rd == link_ra) || (rd == link_t0);
    assign rs1_is_link = (rs1 == link_ra) || (rs1 == link_t0);

    always_comb begin
        rec.pc         = pc;
        rec.rs1_val    = rs1_val;
        rec.rs2_val    = rs2_val;
        rec.funct3     = instr[funct3_lsb +: funct3_w];
        rec.is_jal     = (opcode == opcode_jal);
        rec.is_jalr    = (opcode == opcode_jalr);
        rec.is_cond    = (opcode == opcode_branch);
        // anything outside the three control-transfer opcodes
        rec.is_illegal = !(rec.is_jal || rec.is_jalr || rec.is_cond);
        rec.uses_rd    = (rd != '0);
        // calls write a link register, returns read one and write none
        rec.is_call    = (rec.is_jal || rec.is_jalr) && rd_is_link;
        rec.is_return  = rec.is_jalr && rs1_is_link && !rd_is_link;
        if (rec.is_jal) begin
            rec.offset = imm_j;
        end else if (rec.is_jalr) begin
            rec.offset = imm_i;
        end else begin
            rec.offset = imm_b;
        end
    end

    ////////////////////////////////////////////////////////////
    // issue handshake and output register
    ////////////////////////////////////////////////////////////
    // slot frees up on the edge its record leaves
    assign slot_free = !dec_out.valid || dec_out.ready;
    assign capture   = issue_req && !issue_ack && slot_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ack     <= 1'b0;
            dec_out.valid <= 1'b0;
        end else begin
            if (capture) begin
                issue_ack <= 1'b1;
            end else if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0;
            end
            if (capture) begin
                dec_out.valid <= 1'b1;
            end else if (dec_out.ready) begin
                dec_out.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_out.payload <= rec;
        end
    end

    // ack only rises when the previous record has gone downstream
    assert property (@(posedge clk) disable iff (rst)
        $rose(issue_ack) |-> $past(!dec_out.valid || dec_out.ready));

endmodule

/* hdl/branch_execute.sv */
`timescale 1ns/1ps

module branch_execute
    import branch_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    stage_if.dst dec_in,
    stage_if.src ex_out
);

    decoded_branch_t d;
    branch_outcome_t o;

    logic            take;
    logic            use_signed;
    logic [xlen:0]   a_ext;
    logic [xlen:0]   b_ext;
    logic            lt;
    logic            eq;
    logic            cmp;
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    assign d = dec_in.payload;

    ////////////////////////////////////////////////////////////
    // flow control
    ////////////////////////////////////////////////////////////
    // accept when empty or when the held outcome leaves this edge
    assign dec_in.ready = !ex_out.valid || ex_out.ready;
    assign take         = dec_in.valid && dec_in.ready;

    ////////////////////////////////////////////////////////////
    // comparator
    ////////////////////////////////////////////////////////////
    // funct3[1] set means bltu/bgeu
    assign use_signed = !d.funct3[1];

    // one extra bit so a single signed compare covers both cases
    assign a_ext = {use_signed & d.rs1_val[xlen-1], d.rs1_val};
    assign b_ext = {use_signed & d.rs2_val[xlen-1], d.rs2_val};

    assign lt = $signed(a_ext) < $signed(b_ext);
    assign eq = (d.rs1_val == d.rs2_val);

    // funct3[2] picks less-than over equality
    assign cmp = d.funct3[2] ? lt : eq;

    ////////////////////////////////////////////////////////////
    // target and link adders
    ////////////////////////////////////////////////////////////
    // jalr is register relative, everything else pc relative
    assign base = d.is_jalr ? d.rs1_val : d.pc;
    assign sum  = base + d.offset;

    always_comb begin
        if (d.is_illegal) begin
            o.taken = 1'b0;
        end else if (d.is_cond) begin
            // funct3[0] inverts, bne and bge
            o.taken = cmp ^ d.funct3[0];
        end else begin
            o.taken = 1'b1;
        end
        // bit 0 dropped, odd jalr sums included
        o.target     = {sum[xlen-1:1], 1'b0};
        o.link       = d.pc + xlen'(4);
        o.writes_rd  = d.uses_rd && (d.is_jal || d.is_jalr);
        o.is_call    = d.is_call;
        o.is_return  = d.is_return;
        o.is_illegal = d.is_illegal;
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_out.valid <= 1'b0;
        end else if (take) begin
            ex_out.valid <= 1'b1;
        end else if (ex_out.ready) begin
            ex_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ex_out.payload <= o;
        end
    end

    // targets leave halfword aligned whatever the operands were
    assert property (@(posedge clk) disable iff (rst)
        ex_out.valid |-> !ex_out.payload.target[0]);

endmodule

/* hdl/branch_result.sv */
`timescale 1ns/1ps

module branch_result
    import branch_types_pkg::*;
#(
    parameter int ras_depth = 4
) (
    input  logic            clk,
    input  logic            rst,
    stage_if.dst            res_in,
    output logic            res_req,
    input  logic            res_ack,
    output logic            res_taken,
    output logic [xlen-1:0] res_target,
    output logic [xlen-1:0] res_link,
    output logic            res_writes_rd,
    output logic            res_illegal,
    output logic            res_ras_valid,
    output logic [xlen-1:0] res_ras_addr
);

    branch_outcome_t o;

    logic            accept;
    logic            ras_push;
    logic            ras_pop;
    logic            ras_top_valid;
    logic [xlen-1:0] ras_top_addr;
    logic            predict;

    assign o = res_in.payload;

    ////////////////////////////////////////////////////////////
    // return stack, updated in program order
    ////////////////////////////////////////////////////////////
    // idle only once both req and ack are back low
    assign res_in.ready = !res_req && !res_ack;
    assign accept       = res_in.valid && res_in.ready;

    assign ras_push = accept && o.is_call;
    assign ras_pop  = accept && o.is_return && ras_top_valid;
    // prediction is the top before this edge's update
    assign predict  = o.is_return && ras_top_valid;

    return_stack #(
        .depth(ras_depth)
    ) ras0 (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (o.link),
        .top_valid (ras_top_valid),
        .top_addr  (ras_top_addr)
    );

    ////////////////////////////////////////////////////////////
    // four-phase result port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            res_req <= 1'b0;
        end else if (accept) begin
            res_req <= 1'b1;
        end else if (res_ack) begin
            res_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_taken     <= o.taken;
            res_target    <= o.target;
            res_link      <= o.link;
            res_writes_rd <= o.writes_rd;
            res_illegal   <= o.is_illegal;
            res_ras_valid <= predict;
            res_ras_addr  <= predict ? ras_top_addr : '0;
        end
    end

    // outcome held steady until the consumer acks it
    assert property (@(posedge clk) disable iff (rst)
        (res_req && !res_ack) |=> $stable({res_taken, res_target, res_link, res_writes_rd,
                                           res_illegal, res_ras_valid, res_ras_addr}));

endmodule

/* hdl/branch_top.sv */
`timescale 1ns/1ps

module branch_top
    import branch_types_pkg::*;
#(
    parameter int ras_depth = 4
) (
    input  logic            clk,
    input  logic            rst,

    // issue side, four-phase
    input  logic            issue_req,
    output logic            issue_ack,
    input  logic [ilen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_val,
    input  logic [xlen-1:0] rs2_val,

    // result side, four-phase
    output logic            res_req,
    input  logic            res_ack,
    output logic            res_taken,
    output logic [xlen-1:0] res_target,
    output logic [xlen-1:0] res_link,
    output logic            res_writes_rd,
    output logic            res_illegal,
    output logic            res_ras_valid,
    output logic [xlen-1:0] res_ras_addr
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////
    stage_if #(.payload_t(decoded_branch_t)) dec_to_ex ();
    stage_if #(.payload_t(branch_outcome_t)) ex_to_res ();

    ////////////////////////////////////////////////////////////
    // decode, execute, result
    ////////////////////////////////////////////////////////////
    branch_decode dec0 (
        .clk       (clk),
        .rst       (rst),
        .issue_req (issue_req),
        .issue_ack (issue_ack),
        .instr     (instr),
        .pc        (pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .dec_out   (dec_to_ex.src)
    );

    branch_execute ex0 (
        .clk    (clk),
        .rst    (rst),
        .dec_in (dec_to_ex.dst),
        .ex_out (ex_to_res.src)
    );

    // owns the return stack, depth passed through
    branch_result #(
        .ras_depth(ras_depth)
    ) res0 (
        .clk           (clk),
        .rst           (rst),
        .res_in        (ex_to_res.dst),
        .res_req       (res_req),
        .res_ack       (res_ack),
        .res_taken     (res_taken),
        .res_target    (res_target),
        .res_link      (res_link),
        .res_writes_rd (res_writes_rd),
        .res_illegal   (res_illegal),
        .res_ras_valid (res_ras_valid),
        .res_ras_addr  (res_ras_addr)
    );

endmodule

/* hdl/branch_types_pkg.sv */
package branch_types_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    // data and address width
    localparam int xlen = 32;
    // raw instruction word, no compressed forms
    localparam int ilen = 32;

    ////////////////////////////////////////////////////////////
    // decode to execute
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [2:0]      funct3;
        logic            is_jal;
        logic            is_jalr;
        logic            is_cond;
        logic            is_illegal;
        logic            uses_rd;
        logic            is_call;
        logic            is_return;
        // sign extended, bit 0 already zero for J and B forms
        logic [xlen-1:0] offset;
    } decoded_branch_t;

    ////////////////////////////////////////////////////////////
    // execute to result
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
        logic [xlen-1:0] link;
        logic            writes_rd;
        logic            is_call;
        logic            is_return;
        logic            is_illegal;
    } branch_outcome_t;

endpackage

/* hdl/return_stack.sv */
`timescale 1ns/1ps

module return_stack
    import branch_types_pkg::*;
#(
    parameter int depth = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  logic            pop,
    input  logic [xlen-1:0] push_addr,
    output logic            top_valid,
    output logic [xlen-1:0] top_addr
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [xlen-1:0]  entries [depth];
    logic [ptr_w-1:0] ptr;
    logic [cnt_w-1:0] count;
    logic [ptr_w-1:0] ptr_pop;
    logic [cnt_w-1:0] cnt_pop;
    logic [ptr_w-1:0] ptr_next;
    logic [cnt_w-1:0] cnt_next;

    ////////////////////////////////////////////////////////////
    // pointer update, pop before push
    ////////////////////////////////////////////////////////////
    always_comb begin
        ptr_pop = ptr;
        cnt_pop = count;
        // empty pop leaves everything alone
        if (pop && (count != '0)) begin
            ptr_pop = (ptr == '0) ? ptr_w'(depth - 1) : ptr - 1'b1;
            cnt_pop = count - 1'b1;
        end
        ptr_next = ptr_pop;
        cnt_next = cnt_pop;
        if (push) begin
            ptr_next = (ptr_pop == ptr_w'(depth - 1)) ? '0 : ptr_pop + 1'b1;
            // full: oldest slot is overwritten, count saturates
            if (cnt_pop != cnt_w'(depth)) begin
                cnt_next = cnt_pop + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else begin
            ptr   <= ptr_next;
            count <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[ptr_next] <= push_addr;
        end
    end

    assign top_valid = (count != '0);
    assign top_addr  = entries[ptr];

    // the result stage only pops a stack that holds something
    assert property (@(posedge clk) disable iff (rst)
        (pop && !top_valid) |-> push);

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    ////////////////////////////////////////////////////////////
    // major opcodes of the control-transfer group
    ////////////////////////////////////////////////////////////
    localparam int opcode_w = 7;

    localparam logic [opcode_w-1:0] opcode_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] opcode_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] opcode_branch = 7'b1100011;

    // branch conditions, funct3 of BRANCH
    localparam int funct3_w = 3;

    localparam logic [funct3_w-1:0] funct3_beq  = 3'b000;
    localparam logic [funct3_w-1:0] funct3_bne  = 3'b001;
    localparam logic [funct3_w-1:0] funct3_blt  = 3'b100;
    localparam logic [funct3_w-1:0] funct3_bge  = 3'b101;
    localparam logic [funct3_w-1:0] funct3_bltu = 3'b110;
    localparam logic [funct3_w-1:0] funct3_bgeu = 3'b111;

    ////////////////////////////////////////////////////////////
    // register numbers and field positions
    ////////////////////////////////////////////////////////////
    localparam int reg_w = 5;

    // x1 and x5, the two link registers of the calling convention
    localparam logic [reg_w-1:0] link_ra = 5'd1;
    localparam logic [reg_w-1:0] link_t0 = 5'd5;

    // low bit of each field, width from above
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;

endpackage

/* hdl/stage_if.sv */
`timescale 1ns/1ps

// ready/valid link between two pipeline stages
// payload type set per instance
interface stage_if #(
    parameter type payload_t = logic
);

    // valid and payload come from the producer
    logic     valid;
    logic     ready;
    payload_t payload;

    // transfer on any edge with valid and ready both high
    // producer keeps valid and payload steady until then

    modport src (
        output valid,
        output payload,
        input  ready
    );

    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

/* list.f */
+incdir+testbench
hdl/rv_isa_pkg.sv
hdl/branch_types_pkg.sv
hdl/stage_if.sv
hdl/branch_decode.sv
hdl/branch_execute.sv
hdl/return_stack.sv
hdl/branch_result.sv
hdl/branch_top.sv
testbench/branch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module branch_tb \
    -f list.f -o branch_sim > sim.log 2>&1 \
    && ./obj_dir/branch_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

/* testbench/branch_model.svh */
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// instruction classes shared by stimulus and model
localparam int kind_cond    = 0;
localparam int kind_jal     = 1;
localparam int kind_jalr    = 2;
localparam int kind_illegal = 3;

typedef struct {
    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic            writes_rd;
    logic            illegal;
    logic            ras_valid;
    logic [xlen-1:0] ras_addr;
} expect_t;

// newest entry at the back, oldest falls off the front
logic [xlen-1:0] model_ras [$];

task automatic model_reset();
    model_ras.delete();
endtask

// x1 or x5
function automatic logic is_link(input logic [4:0] r);
    return (r == link_ra) || (r == link_t0);
endfunction

////////////////////////////////////////////////////////////
// outcome of one instruction, stack updated in order
////////////////////////////////////////////////////////////
task automatic resolve_branch(
    input  int              kind,
    input  logic [2:0]      f3,
    input  logic [4:0]      rd,
    input  logic [4:0]      rs1r,
    input  logic [xlen-1:0] pc_v,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [xlen-1:0] off,
    output expect_t         e
);
    logic            cmp;
    logic            jump;
    logic            call;
    logic            ret;
    logic [xlen-1:0] sum;
    case (f3)
        funct3_beq:  cmp = (a == b);
        funct3_bne:  cmp = (a != b);
        funct3_blt:  cmp = ($signed(a) < $signed(b));
        funct3_bge:  cmp = ($signed(a) >= $signed(b));
        funct3_bltu: cmp = (a < b);
        funct3_bgeu: cmp = (a >= b);
        default:     cmp = 1'b0;
    endcase
    jump      = (kind == kind_jal) || (kind == kind_jalr);
    e.illegal = (kind == kind_illegal);
    if (e.illegal) begin
        e.taken = 1'b0;
    end else if (kind == kind_cond) begin
        e.taken = cmp;
    end else begin
        e.taken = 1'b1;
    end
    // jalr adds to rs1, the rest to pc
    sum         = (kind == kind_jalr) ? a + off : pc_v + off;
    e.target    = {sum[xlen-1:1], 1'b0};
    e.link      = pc_v + 32'd4;
    e.writes_rd = jump && (rd != 5'd0);
    call        = jump && is_link(rd);
    ret         = (kind == kind_jalr) && is_link(rs1r) && !is_link(rd);
    // empty stack gives no prediction and no pop
    e.ras_valid = ret && (model_ras.size() != 0);
    e.ras_addr  = '0;
    if (e.ras_valid) begin
        e.ras_addr = model_ras[$];
        void'(model_ras.pop_back());
    end
    if (call) begin
        model_ras.push_back(e.link);
        if (model_ras.size() > ras_depth) begin
            void'(model_ras.pop_front());
        end
    end
endtask

`endif

/* testbench/branch_tb.sv */
`timescale 1ns/1ps

module branch_tb
    import rv_isa_pkg::*;
    import branch_types_pkg::*;
();

    localparam int ras_depth        = 4;
    localparam int clk_period       = 100;
    localparam int drive_skew       = 1;
    localparam int reset_cycles     = 8;
    // deep nesting first, then more returns than calls
    localparam int nest_calls       = 6;
    localparam int nest_returns     = 8;
    localparam int random_count     = 300;
    localparam int n_instr          = nest_calls + nest_returns + random_count;
    localparam int cycles_per_instr = 40;
    localparam int watchdog_cycles  = reset_cycles + n_instr * cycles_per_instr;

    `include "branch_model.svh"

    logic            clk;
    logic            rst;
    logic            issue_req;
    logic            issue_ack;
    logic [ilen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            res_req;
    logic            res_ack;
    logic            res_taken;
    logic [xlen-1:0] res_target;
    logic [xlen-1:0] res_link;
    logic            res_writes_rd;
    logic            res_illegal;
    logic            res_ras_valid;
    logic [xlen-1:0] res_ras_addr;

    // pregenerated stimulus, one slot per instruction
    int              st_kind   [n_instr];
    logic [2:0]      st_funct3 [n_instr];
    logic [4:0]      st_rd     [n_instr];
    logic [4:0]      st_rs1    [n_instr];
    logic [xlen-1:0] st_off    [n_instr];
    logic [ilen-1:0] st_word   [n_instr];
    logic [xlen-1:0] st_pc     [n_instr];
    logic [xlen-1:0] st_a      [n_instr];
    logic [xlen-1:0] st_b      [n_instr];
    int              issue_gap [n_instr];
    int              ack_delay [n_instr];

    int          pending [$];
    int          errors;
    int          issued;
    int          results;
    logic [31:0] lfsr;
    logic        issue_req_q;
    logic        issue_ack_q;
    logic        res_req_q;
    logic        res_ack_q;

    branch_top #(
        .ras_depth(ras_depth)
    ) dut0 (
        .clk           (clk),
        .rst           (rst),
        .issue_req     (issue_req),
        .issue_ack     (issue_ack),
        .instr         (instr),
        .pc            (pc),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .res_req       (res_req),
        .res_ack       (res_ack),
        .res_taken     (res_taken),
        .res_target    (res_target),
        .res_link      (res_link),
        .res_writes_rd (res_writes_rd),
        .res_illegal   (res_illegal),
        .res_ras_valid (res_ras_valid),
        .res_ras_addr  (res_ras_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #drive_skew;
    endtask

    task automatic count_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input int idx);
        errors++;
        $display("[ERROR] %s: got %h, expected %h (instruction %0d)", name, got, exp, idx);
    endtask

    // sel 4 forces a call, 5 a return, 6 an illegal opcode
    task automatic build_item(input int i, input int sel);
        logic [xlen-1:0] off;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [19:0]     r;
        logic [4:0]      rd;
        logic [4:0]      rs1r;
        logic [2:0]      f3;
        logic [6:0]      op;
        int              kind;
        a    = rand_bits(32);
        b    = rand_bits(32);
        rd   = 5'(rand_bits(5));
        rs1r = 5'(rand_bits(5));
        f3   = 3'b000;
        case (sel)
            2: kind = kind_jal;
            3: kind = kind_jalr;
            4: begin
                kind = rand_bits(1) ? kind_jal : kind_jalr;
                rd   = rand_bits(1) ? link_t0 : link_ra;
            end
            5: begin
                kind = kind_jalr;
                rs1r = rand_bits(1) ? link_t0 : link_ra;
                rd   = 5'd0;
            end
            6: kind = kind_illegal;
            default: kind = kind_cond;
        endcase
        case (kind)
            kind_jal: begin
                r          = 20'(rand_bits(20));
                off        = {{11{r[19]}}, r, 1'b0};
                st_word[i] = {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
            end
            kind_jalr: begin
                // any 12-bit offset, so odd sums show up
                r          = 20'(rand_bits(12));
                off        = {{20{r[11]}}, r[11:0]};
                st_word[i] = {off[11:0], rs1r, 3'b000, rd, opcode_jalr};
            end
            kind_cond: begin
                case (rand_bits(3) % 6)
                    0: f3 = funct3_beq;
                    1: f3 = funct3_bne;
                    2: f3 = funct3_blt;
                    3: f3 = funct3_bge;
                    4: f3 = funct3_bltu;
                    default: f3 = funct3_bgeu;
                endcase
                // equal operands and sign-only differences are the corner cases
                case (rand_bits(2))
                    0: b = a;
                    1: b = a ^ 32'h8000_0000;
                    default: b = b;
                endcase
                r          = 20'(rand_bits(12));
                off        = {{19{r[11]}}, r[11:0], 1'b0};
                st_word[i] = {off[12], off[10:5], 5'(rand_bits(5)), rs1r, f3, off[4:1],
                              off[11], opcode_branch};
            end
            default: begin
                op = 7'(rand_bits(7));
                while (op == opcode_jal || op == opcode_jalr || op == opcode_branch) begin
                    op = 7'(rand_bits(7));
                end
                off        = '0;
                st_word[i] = {25'(rand_bits(25)), op};
            end
        endcase
        st_kind[i]   = kind;
        st_funct3[i] = f3;
        st_rd[i]     = rd;
        st_rs1[i]    = rs1r;
        st_off[i]    = off;
        st_pc[i]     = rand_bits(30) << 2;
        st_a[i]      = a;
        st_b[i]      = b;
        issue_gap[i] = int'(rand_bits(1));
        ack_delay[i] = int'(rand_bits(3));
    endtask

    ////////////////////////////////////////////////////////////
    // four-phase drivers
    ////////////////////////////////////////////////////////////
    task automatic issue_all();
        for (int i = 0; i < n_instr; i++) begin
            repeat (issue_gap[i]) next_cycle();
            instr     = st_word[i];
            pc        = st_pc[i];
            rs1_val   = st_a[i];
            rs2_val   = st_b[i];
            issue_req = 1'b1;
            pending.push_back(i);
            issued++;
            do next_cycle(); while (!issue_ack);
            issue_req = 1'b0;
            do next_cycle(); while (issue_ack);
        end
    endtask

    task automatic collect_all();
        expect_t e;
        int      idx;
        for (int k = 0; k < n_instr; k++) begin
            do next_cycle(); while (!res_req);
            if (pending.size() == 0) begin
                count_failure("result arrived with no instruction outstanding");
            end else begin
                idx = pending.pop_front();
                resolve_branch(st_kind[idx], st_funct3[idx], st_rd[idx], st_rs1[idx],
                               st_pc[idx], st_a[idx], st_b[idx], st_off[idx], e);
                if (res_taken !== e.taken)
                    report_mismatch("res_taken", 32'(res_taken), 32'(e.taken), idx);
                if (res_link !== e.link)
                    report_mismatch("res_link", res_link, e.link, idx);
                if (res_writes_rd !== e.writes_rd)
                    report_mismatch("res_writes_rd", 32'(res_writes_rd), 32'(e.writes_rd), idx);
                if (res_illegal !== e.illegal)
                    report_mismatch("res_illegal", 32'(res_illegal), 32'(e.illegal), idx);
                // target carries no meaning for an illegal opcode
                if (!e.illegal && res_target !== e.target)
                    report_mismatch("res_target", res_target, e.target, idx);
                if (res_ras_valid !== e.ras_valid)
                    report_mismatch("res_ras_valid", 32'(res_ras_valid), 32'(e.ras_valid), idx);
                if (e.ras_valid && res_ras_addr !== e.ras_addr)
                    report_mismatch("res_ras_addr", res_ras_addr, e.ras_addr, idx);
            end
            // hold off the ack for back-pressure
            repeat (ack_delay[k]) next_cycle();
            res_ack = 1'b1;
            do next_cycle(); while (res_req);
            res_ack = 1'b0;
        end
    endtask

    // an ack may only rise while its req is up
    always @(negedge clk) begin
        if (!rst) begin
            if (issue_ack && !issue_ack_q && !(issue_req || issue_req_q))
                count_failure("issue_ack rose while issue_req was low");
            // result request must stay up until its ack is seen
            if (!res_req && res_req_q && !res_ack_q)
                count_failure("res_req dropped before res_ack was raised");
            // each rising res_req is one result offered
            if (res_req && !res_req_q)
                results++;
        end
        issue_req_q <= issue_req;
        issue_ack_q <= issue_ack;
        res_req_q   <= res_req;
        res_ack_q   <= res_ack;
    end

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        issue_req = 1'b0;
        res_ack   = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_val   = '0;
        rs2_val   = '0;
        errors    = 0;
        issued    = 0;
        results   = 0;
        lfsr      = 32'h7468_dabf;
        model_reset();
        for (int i = 0; i < nest_calls; i++) build_item(i, 4);
        for (int i = 0; i < nest_returns; i++) build_item(nest_calls + i, 5);
        for (int i = nest_calls + nest_returns; i < n_instr; i++) begin
            build_item(i, int'(rand_bits(3)));
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_skew;
        rst = 1'b0;
        fork
            issue_all();
            collect_all();
        join
        repeat (10) next_cycle();
        if (res_req) count_failure("result port raised a request with nothing outstanding");
        if (results != issued) count_failure("number of results differs from number of issues");
        $display("errors: %0d, issued: %0d, results: %0d", errors, issued, results);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d cycles with %0d of %0d results seen",
                 watchdog_cycles, results, n_instr);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
